/* cache_settings.svh */
// instruction cache settings with the address, data and index widths and the memory latency.
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// the CPU fetches 16-bit words over a 15-bit word address.
`define ADDR_BITS 15
`define DATA_BITS 16

// 256 lines, and a page of 256 words.
`define INDEX_BITS 8

// cycles from an accepted read to its success pulse.
`define MEM_LATENCY 2

`endif

/* cache_pkg.sv */
// instruction cache package with the line word and the memory bus structs.
`include "cache_settings.svh"

package cache_pkg;

	// one cache line. A set invalid bit marks an empty line.
	typedef struct packed {
		logic [`ADDR_BITS-1:0] address;
		logic                  invalid;
		logic [`DATA_BITS-1:0] instr;
	} cache_line_t;

	typedef struct packed {
		logic                  rd_req;  // held high while reads are wanted.
		logic [`ADDR_BITS-1:0] address;
	} mem_req_t;

	typedef struct packed {
		logic                  success;  // one cycle per accepted read.
		logic [`ADDR_BITS-1:0] address;
		logic [`DATA_BITS-1:0] data;
	} mem_resp_t;

	// preload port of the program store.
	typedef struct packed {
		logic                  en;
		logic [`ADDR_BITS-1:0] address;
		logic [`DATA_BITS-1:0] data;
	} load_t;

endpackage

/* line_ram.sv */
// cache line storage with one synchronous read port and one write port.
`timescale 1ns/1ps

module line_ram #(
	parameter int BITS = 32,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic [ADDRESS_BITS-1:0] rd_address,
	output logic [BITS-1:0]         data_out,
	input  logic [ADDRESS_BITS-1:0] wr_address,
	input  logic [BITS-1:0]         data_in,
	input  logic                    wr
);

	localparam int WORDS = 1 << ADDRESS_BITS;

	logic [BITS-1:0] ram [0:WORDS-1];

	// every line starts empty, so the first fetch of any address misses.
	initial begin
		cache_pkg::cache_line_t empty_line;
		empty_line = '0;
		empty_line.invalid = 1'b1;
		for (int i = 0; i < WORDS; i++) begin
			ram[i] = BITS'(empty_line);
		end
	end

	always_ff @(posedge CLK) begin
		if (wr) begin
			ram[wr_address] <= data_in;
		end
		data_out <= ram[rd_address];  // a line written this cycle reads back next cycle.
	end

endmodule

/* icache_lookup.sv */
// instruction cache lookup that registers the fetch address, checks its line and stores fills.
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_lookup (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic [`ADDR_BITS-1:0]             fetch_address,
	input  cache_pkg::mem_resp_t              mem_resp,
	output logic [`DATA_BITS-1:0]             instr,
	output logic                              miss,
	output logic                              new_request,
	output logic [`ADDR_BITS-`INDEX_BITS-1:0] page,
	output logic [`INDEX_BITS-1:0]            index
);

	logic [`ADDR_BITS-1:0] address_x;   // fetch address, one cycle old.
	logic [`ADDR_BITS-1:0] address_xx;  // fetch address, two cycles old.

	cache_pkg::cache_line_t line_rd;
	cache_pkg::cache_line_t line_wr;

	// each returned word becomes a valid line at the index of its own address.
	always_comb begin
		line_wr.address = mem_resp.address;
		line_wr.invalid = 1'b0;
		line_wr.instr = mem_resp.data;
	end

	// the line is read with the raw fetch address, so it lines up with address_x.
	line_ram #(
		.BITS($bits(cache_pkg::cache_line_t)),
		.ADDRESS_BITS(`INDEX_BITS)
	) line_ram_i (
		.CLK(CLK),
		.rd_address(fetch_address[`INDEX_BITS-1:0]),
		.data_out(line_rd),
		.wr_address(mem_resp.address[`INDEX_BITS-1:0]),
		.data_in(line_wr),
		.wr(mem_resp.success)
	);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			address_x <= '0;
			address_xx <= '0;
			new_request <= 1'b0;
		end else begin
			address_x <= fetch_address;
			address_xx <= address_x;
			// an address change only lasts one cycle, which makes this a strobe.
			new_request <= (address_x != address_xx) && miss;
		end
	end

	// the full stored address is compared, not just the page bits.
	assign miss = (line_rd.address != address_x) || line_rd.invalid;
	assign instr = line_rd.instr;

	assign index = address_x[`INDEX_BITS-1:0];
	assign page = address_xx[`ADDR_BITS-1:`INDEX_BITS];

endmodule

/* fill_sequencer.sv */
// cache fill sequencer that reads the missed line and then the rest of its page.
`timescale 1ns/1ps
`include "cache_settings.svh"

module fill_sequencer (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              new_request,
	input  logic [`INDEX_BITS-1:0]            index,
	input  logic [`ADDR_BITS-`INDEX_BITS-1:0] page,
	input  cache_pkg::mem_resp_t              mem_resp,
	output cache_pkg::mem_req_t               mem_req
);

	// the top bit sets once the last line of the page has come back.
	logic [`INDEX_BITS:0] fill_count;
	logic                 line_back;

	always_comb begin
		mem_req.address = {page, fill_count[`INDEX_BITS-1:0]};
		mem_req.rd_req = !fill_count[`INDEX_BITS];
	end

	// reads stay in flight back to back, so a success can belong to an older address.
	// Only the return of the line being asked for moves the counter on.
	assign line_back = mem_resp.success && (mem_resp.address == mem_req.address);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			fill_count <= '0;  // fill page zero from line zero after reset.
		end else if (new_request) begin
			fill_count <= {1'b0, index};
		end else if (line_back && !fill_count[`INDEX_BITS]) begin
			fill_count <= fill_count + 1'b1;
		end
	end

	// a refused read returns nothing.
	// The counter then holds and the same address is asked for again.

endmodule

/* program_memory.sv */
// program memory with a single-master arbiter, a load port and a fixed read latency.
`timescale 1ns/1ps
`include "cache_settings.svh"

module program_memory (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  cache_pkg::mem_req_t  mem_req,
	input  logic                 busy,
	input  cache_pkg::load_t     load,
	output cache_pkg::mem_resp_t mem_resp
);

	localparam int DEPTH = `MEM_LATENCY;
	localparam int WORDS = 1 << `ADDR_BITS;

	logic [`DATA_BITS-1:0] store [0:WORDS-1];

	logic [DEPTH-1:0]      success_pipe;
	logic [`ADDR_BITS-1:0] address_pipe [0:DEPTH-1];
	logic [`DATA_BITS-1:0] data_pipe [0:DEPTH-1];
	logic                  grant;

	assign grant = mem_req.rd_req && !busy;  // busy refuses the read outright.

	always_ff @(posedge CLK) begin
		if (load.en) begin
			store[load.address] <= load.data;
		end
	end

	// the store read is the first stage, later stages only delay the word.
	always_ff @(posedge CLK) begin
		address_pipe[0] <= mem_req.address;
		data_pipe[0] <= store[mem_req.address];
		for (int i = 1; i < DEPTH; i++) begin
			address_pipe[i] <= address_pipe[i-1];
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			success_pipe <= '0;
		end else begin
			success_pipe[0] <= grant;
			for (int i = 1; i < DEPTH; i++) begin
				success_pipe[i] <= success_pipe[i-1];
			end
		end
	end

	always_comb begin
		mem_resp.success = success_pipe[DEPTH-1];
		mem_resp.address = address_pipe[DEPTH-1];  // the CPU side files the word by this.
		mem_resp.data = data_pipe[DEPTH-1];
	end

endmodule

/* icache_top.sv */
// instruction fetch top level with the cache lookup, the fill sequencer and program memory.
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_top (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  logic [`ADDR_BITS-1:0] fetch_address,
	input  logic                  busy,
	input  cache_pkg::load_t      load,
	output logic [`DATA_BITS-1:0] instr,
	output logic                  instr_miss
);

	logic                              new_request;
	logic [`ADDR_BITS-`INDEX_BITS-1:0] page;
	logic [`INDEX_BITS-1:0]            index;

	cache_pkg::mem_req_t  mem_req;
	cache_pkg::mem_resp_t mem_resp;  // goes to both the lookup and the sequencer.

	icache_lookup lookup_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.fetch_address(fetch_address),
		.mem_resp(mem_resp),
		.instr(instr),
		.miss(instr_miss),
		.new_request(new_request),
		.page(page),
		.index(index)
	);

	fill_sequencer sequencer_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.new_request(new_request),
		.index(index),
		.page(page),
		.mem_resp(mem_resp),
		.mem_req(mem_req)
	);

	program_memory memory_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.mem_req(mem_req),
		.busy(busy),
		.load(load),
		.mem_resp(mem_resp)
	);

endmodule

/* icache_checker.sv */
// fetch checker that compares returned instructions and hit timing against expected words.
`timescale 1ns/1ps
`include "cache_settings.svh"

module icache_checker (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic [`DATA_BITS-1:0]  instr,
	input  logic                   instr_miss,
	input  cache_pkg::cache_line_t expected,
	input  logic [1:0]             timing,
	output logic                   checked,
	output int                     mismatch_count
);

	localparam logic [1:0] MISS_FIRST = 2'd1;
	localparam logic [1:0] HIT_FIRST = 2'd2;

	cache_pkg::cache_line_t expected_q;  // moves with the DUT's registered fetch address.
	logic [1:0]             timing_q;
	logic                   first_look;

	always @(posedge CLK) begin
		expected_q <= expected;
		timing_q <= timing;
	end

	// the first look is the cycle right after the address was registered.
	always @(negedge CLK) begin
		if (!RSTb) begin
			checked = 1'b0;
			first_look = 1'b1;
			mismatch_count = 0;
		end else if (expected_q.invalid) begin
			checked = 1'b0;
			first_look = 1'b1;
		end else if (!checked) begin
			if (first_look) begin
				if (timing_q == MISS_FIRST && !instr_miss) begin
					$display("MISMATCH at time %0t: address %h hit at once, a miss was expected",
						$time, expected_q.address);
					mismatch_count = mismatch_count + 1;
				end
				if (timing_q == HIT_FIRST && instr_miss) begin
					$display("MISMATCH at time %0t: address %h missed, a hit was expected",
						$time, expected_q.address);
					mismatch_count = mismatch_count + 1;
				end
				first_look = 1'b0;
			end
			if (!instr_miss) begin
				if (instr !== expected_q.instr) begin
					$display("MISMATCH at time %0t: address %h returned %h, expected %h",
						$time, expected_q.address, instr, expected_q.instr);
					mismatch_count = mismatch_count + 1;
				end
				checked = 1'b1;  // held until the testbench closes this fetch.
			end
		end
	end

endmodule

/* tb_icache.sv */
// instruction cache testbench that preloads program memory and replays fetches from a data file.
`timescale 1ns/1ps
`include "cache_settings.svh"

module tb_icache;

	localparam int FETCH_TIMEOUT = 1000;
	localparam int RELEASE_TIMEOUT = 10;
	localparam logic [`ADDR_BITS-1:0] IDLE_ADDRESS = 15'h7f00;  // a page no test line uses.

	logic                  CLK;
	logic                  RSTb;
	logic [`ADDR_BITS-1:0] fetch_address;
	logic                  busy;
	cache_pkg::load_t      load;
	logic [`DATA_BITS-1:0] instr;
	logic                  instr_miss;

	cache_pkg::cache_line_t expected;  // a set invalid bit means no fetch is open.
	logic [1:0]             timing;
	logic                   checked;
	int                     mismatch_count;

	int     timeout_count;
	int     file_errors;
	int     fetch_count;
	int     busy_left;
	integer seed;

	icache_top icache_top_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.fetch_address(fetch_address),
		.busy(busy),
		.load(load),
		.instr(instr),
		.instr_miss(instr_miss)
	);

	icache_checker checker_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.instr(instr),
		.instr_miss(instr_miss),
		.expected(expected),
		.timing(timing),
		.checked(checked),
		.mismatch_count(mismatch_count)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#4 CLK = ~CLK;
		end
	end

	// one clock cycle. busy is drawn at random while the budget lasts.
	task automatic tick();
		logic [31:0] draw;
		@(posedge CLK);
		if (busy_left > 0) begin
			draw = $random(seed);
			busy <= draw[0];
			busy_left = busy_left - 1;
		end else begin
			busy <= 1'b0;
		end
	endtask

	task automatic preload_word(input logic [`ADDR_BITS-1:0] address,
			input logic [`DATA_BITS-1:0] data);
		tick();
		load <= {1'b1, address, data};
		tick();
		load.en <= 1'b0;
	endtask

	task automatic fetch_and_check(input logic [`ADDR_BITS-1:0] address,
			input logic [`DATA_BITS-1:0] value, input logic [1:0] mode);
		int waited;
		tick();
		fetch_address <= address;
		expected <= {address, 1'b0, value};
		timing <= mode;
		fetch_count++;
		waited = 0;
		tick();
		while (!checked && waited < FETCH_TIMEOUT) begin
			tick();
			waited++;
		end
		if (!checked) begin
			$display("error: address %h gave no hit within %0d cycles", address, FETCH_TIMEOUT);
			timeout_count++;
		end
		expected.invalid <= 1'b1;  // the address stays on the bus.
		waited = 0;
		tick();
		while (checked && waited < RELEASE_TIMEOUT) begin
			tick();
			waited++;
		end
		if (checked) begin
			$display("error: checker did not close the fetch of address %h", address);
			timeout_count++;
		end
	endtask

	initial begin
		int               fd;
		int               n;
		logic [8*120-1:0] text;
		logic [7:0]       kind;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		seed = 24;
		RSTb = 1'b0;
		fetch_address = IDLE_ADDRESS;
		busy = 1'b0;
		load = '0;
		expected = '0;
		expected.invalid = 1'b1;
		timing = 2'd0;
		timeout_count = 0;
		file_errors = 0;
		fetch_count = 0;
		busy_left = 0;
		repeat (2) @(posedge CLK);
		RSTb <= 1'b1;
		fd = $fopen("icache_tests.txt", "r");
		if (fd == 0) begin
			$display("error: could not open icache_tests.txt");
			file_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", kind);
				if (n == 1) begin
					if (kind == "#") begin
						n = $fgets(text, fd);
					end else if (kind == "L" && $fscanf(fd, "%h %h", a, b) == 2) begin
						preload_word(a[`ADDR_BITS-1:0], b[`DATA_BITS-1:0]);
					end else if (kind == "F" && $fscanf(fd, "%h %h %h", a, b, c) == 3) begin
						fetch_and_check(a[`ADDR_BITS-1:0], b[`DATA_BITS-1:0], c[1:0]);
					end else if (kind == "B" && $fscanf(fd, "%h", a) == 1) begin
						busy_left = a;
					end else begin
						$display("error: unreadable line in icache_tests.txt");
						file_errors++;
					end
				end
			end
			$fclose(fd);
		end
		if (fetch_count == 0) begin
			$display("error: no fetch lines were found");
			file_errors++;
		end
		$display("errors: %0d mismatches, %0d timeouts, %0d file errors",
			mismatch_count, timeout_count, file_errors);
		if (mismatch_count + timeout_count + file_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+.
cache_pkg.sv
line_ram.sv
icache_lookup.sv
fill_sequencer.sv
program_memory.sv
icache_top.sv
icache_checker.sv
tb_icache.sv

/* icache_tests.txt */
# L address data | F address expected timing (0 either, 1 miss first, 2 hit at once) | B cycles
# every number is hex, and each word is separated by spaces.
L 0010 a010
L 0011 b011
L 0014 c014
L 0020 d020
L 00ff e0ff
L 0123 1123
L 0124 2124
L 0223 3223
L 0350 4350
L 0351 5351
L 0358 6358
L 03a0 73a0
L 0450 8450
# first fetch after reset, then fill-ahead in page 0
F 0010 a010 1
F 0011 b011 0
F 0014 c014 0
F 0020 d020 0
F 00ff e0ff 0
# same index in pages 1 and 2, then a cached line held
F 0123 1123 1
F 0223 3223 1
F 0123 1123 1
F 0124 2124 0
F 0123 1123 2
# random busy while page 3 and page 4 are filled
B 12c
F 0350 4350 1
F 0351 5351 0
F 0358 6358 0
F 03a0 73a0 0
F 0450 8450 1
F 0350 4350 1
F 0010 a010 0
